// ==== verilog.f ====
src/ad_tx_pkg.sv
src/dac_cfg_if.sv
src/tx_regmap.sv
src/tx_rate_gen.sv
src/tx_channel.sv
src/axi_tx_core.sv
sim/tb_clk_gen.sv
sim/tb_axi_tx_core.sv

// ==== Bender.yml ====
package:
  name: axi_tx_core

sources:
  - src/ad_tx_pkg.sv
  - src/dac_cfg_if.sv
  - src/tx_regmap.sv
  - src/tx_rate_gen.sv
  - src/tx_channel.sv
  - src/axi_tx_core.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_axi_tx_core.sv

// ==== sim/tb_axi_tx_core.sv ====
// tx core testbench covering register access, rate strobes, channel sources, status and sync
module tb_axi_tx_core
  import ad_tx_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_LIMIT = 4;

  typedef struct {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wr;
    reg_word_u         rd;
  } reg_row_t;

  typedef struct {
    int                  ch;
    logic [1:0]          src;
    logic                en;
    logic [SAMPLE_W-1:0] pat;
    logic                fmt;
    logic [SAMPLE_W-1:0] exp;
  } chan_row_t;

  logic dac_clk, up_rstn, up_wreq, up_wack, up_rreq, up_rack;
  logic [ADDR_W-1:0] up_waddr, up_raddr;
  logic [DATA_W-1:0] up_wdata, up_rdata;
  logic dac_valid, dac_sync_in, dac_sync_out, dac_dovf, dac_dunf;
  logic [NUM_CH*SAMPLE_W-1:0] dac_data, adc_data;
  logic dac_enable_i0, dac_enable_q0, dac_enable_i1, dac_enable_q1;
  logic dac_valid_i0, dac_valid_q0, dac_valid_i1, dac_valid_q1;
  logic [DMA_W-1:0] dac_data_i0, dac_data_q0, dac_data_i1, dac_data_q1;

  integer              seed;
  logic                sync_at_ack;
  reg_row_t            reg_rows [6];
  chan_row_t           chan_rows [10];
  logic [DMA_W-1:0]    dma_val [NUM_CH];
  logic [SAMPLE_W-1:0] adc_val [NUM_CH];
  logic [1:0]          cur_src [NUM_CH];
  logic                cur_en [NUM_CH];
  logic [SAMPLE_W-1:0] cur_pat [NUM_CH];

  tb_clk_gen i_tb_clk_gen (.dac_clk (dac_clk), .up_rstn (up_rstn));

  axi_tx_core i_axi_tx_core (.*);

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input reg_word_u got, input reg_word_u exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, what, got.raw, exp.raw));
    end
  endtask

  task automatic check_sample(input logic [SAMPLE_W-1:0] got, input logic [SAMPLE_W-1:0] exp,
                              input string what);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                               $time, what, got, exp));
    end
  endtask

  function automatic reg_word_u cntrl_word(input int rate, input logic r1, input logic fmt,
                                           input logic ext, input logic sync);
    reg_word_u w;
    w.raw               = '0;
    w.common.datarate   = 16'(rate);
    w.common.r1_mode    = r1;
    w.common.dds_format = fmt;
    w.common.ext_sync   = ext;
    w.common.sync       = sync;
    return w;
  endfunction

  function automatic reg_word_u chan_word(input logic en, input logic [1:0] src,
                                          input logic [SAMPLE_W-1:0] pat);
    reg_word_u w;
    w.raw          = '0;
    w.chan.enable  = en;
    w.chan.source  = src;
    w.chan.pattern = pat;
    return w;
  endfunction

  // expected sample for one channel from its source rules
  function automatic logic [SAMPLE_W-1:0] model_sample(input logic [1:0] src, input logic en,
      input logic [SAMPLE_W-1:0] pat, input logic fmt, input int ch,
      input logic [SAMPLE_W-1:0] partner);
    if (!en) return '0;
    case (src)
      SRC_DMA:     return dma_val[ch][DMA_W-1:DMA_W-SAMPLE_W];
      SRC_PATTERN: return pat ^ {fmt, {(SAMPLE_W-1){1'b0}}};
      SRC_ADC:     return adc_val[ch];
      default:     return partner;
    endcase
  endfunction

  function automatic logic enable_out(input int ch);
    case (ch)
      0:       return dac_enable_i0;
      1:       return dac_enable_q0;
      2:       return dac_enable_i1;
      default: return dac_enable_q1;
    endcase
  endfunction

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input reg_word_u data);
    int waited;
    waited = 0;
    @(posedge dac_clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data.raw;
    @(posedge dac_clk);
    up_wreq <= 1'b0;
    @(negedge dac_clk);
    while (!up_wack) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        report_failure($sformatf("write to %h was never acknowledged", addr));
      end
      @(negedge dac_clk);
    end
    if (waited != 0) begin
      report_failure($sformatf("mismatch at %0t ns: write ack %0d cycles late", $time, waited));
    end
    sync_at_ack = dac_sync_out;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output reg_word_u data);
    int waited;
    waited = 0;
    @(posedge dac_clk);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge dac_clk);
    up_rreq <= 1'b0;
    @(negedge dac_clk);
    while (!up_rack) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        report_failure($sformatf("read of %h was never acknowledged", addr));
      end
      @(negedge dac_clk);
    end
    if (waited != 0) begin
      report_failure($sformatf("mismatch at %0t ns: read ack %0d cycles late", $time, waited));
    end
    data = up_rdata;
  endtask

  task automatic read_expect(input logic [ADDR_W-1:0] addr, input reg_word_u exp);
    reg_word_u got;
    bus_read(addr, got);
    check_word(got, exp, $sformatf("read of %h", addr));
  endtask

  task automatic wait_strobe(input int limit);
    int waited;
    waited = 0;
    @(negedge dac_clk);
    while (!dac_valid) begin
      waited++;
      if (waited > limit) begin
        report_failure($sformatf("dac_valid did not strobe within %0d cycles", limit));
      end
      @(negedge dac_clk);
    end
  endtask

  task automatic set_chan_row(input int idx, input int ch, input logic [1:0] src,
                              input logic en, input logic [SAMPLE_W-1:0] pat, input logic fmt);
    chan_rows[idx] = '{ch, src, en, pat, fmt, '0};
  endtask

  initial begin
    reg_word_u           w;
    int                  waited;
    int                  cycles;
    int                  c;
    int                  p;
    int                  rates [4];
    logic                prev_valid;
    logic                q0_seen;
    logic [SAMPLE_W-1:0] partner;
    seed = 58;
    up_wreq     <= 1'b0;
    up_rreq     <= 1'b0;
    up_waddr    <= '0;
    up_raddr    <= '0;
    up_wdata    <= '0;
    adc_data    <= '0;
    dac_sync_in <= 1'b0;
    dac_dovf    <= 1'b0;
    dac_dunf    <= 1'b0;
    dac_data_i0 <= '0;
    dac_data_q0 <= '0;
    dac_data_i1 <= '0;
    dac_data_q1 <= '0;
    rates = '{0, 1, 3, 7};

    // address, write word, expected read word
    reg_rows[0] = '{ADDR_CNTRL, 32'h0005_ffff, cntrl_word(5, 1'b1, 1'b1, 1'b1, 1'b0)};
    reg_rows[1] = '{ADDR_CNTRL, 32'h0000_0001, cntrl_word(0, 1'b0, 1'b0, 1'b0, 1'b0)};
    reg_rows[2] = '{ADDR_CHAN_BASE, 32'hffff_ffff, chan_word(1'b1, SRC_PARTNER, 12'hfff)};
    reg_rows[3] = '{ADDR_CHAN_BASE + 14'd3, 32'h0abc_1235, chan_word(1'b1, SRC_ADC, 12'habc)};
    reg_rows[4] = '{14'h0050, 32'hdead_beef, chan_word(1'b0, SRC_DMA, 12'h000)};
    reg_rows[5] = '{ADDR_CHAN_BASE + 14'd1, 32'h0000_0000, chan_word(1'b0, SRC_DMA, 12'h000)};

    // channel, source, enable, pattern, format
    set_chan_row(0, 0, SRC_DMA, 1'b1, 12'h000, 1'b0);
    set_chan_row(1, 1, SRC_PARTNER, 1'b1, 12'h000, 1'b0);
    set_chan_row(2, 2, SRC_PATTERN, 1'b1, 12'h123, 1'b0);
    set_chan_row(3, 2, SRC_PATTERN, 1'b1, 12'h123, 1'b1);
    set_chan_row(4, 3, SRC_ADC, 1'b1, 12'h000, 1'b1);
    set_chan_row(5, 3, SRC_PARTNER, 1'b1, 12'h000, 1'b1);
    set_chan_row(6, 1, SRC_ADC, 1'b1, 12'h000, 1'b0);
    set_chan_row(7, 0, SRC_PATTERN, 1'b0, 12'h7ff, 1'b0);
    set_chan_row(8, 2, SRC_DMA, 1'b1, 12'h000, 1'b0);
    set_chan_row(9, 0, SRC_PATTERN, 1'b1, 12'h800, 1'b1);

    waited = 0;
    @(negedge dac_clk);
    while (!up_rstn) begin
      waited++;
      if (waited > 20) report_failure("reset was never released");
      @(negedge dac_clk);
    end

    // **************************************************
    // reset values and register access
    // **************************************************
    check_bit(up_wack, 1'b0, "up_wack after reset");
    check_bit(up_rack, 1'b0, "up_rack after reset");
    check_bit(dac_sync_out, 1'b0, "dac_sync_out after reset");
    for (int n = 0; n < NUM_CH; n++) begin
      check_bit(enable_out(n), 1'b0, "dac_enable after reset");
    end
    w.raw = CORE_VERSION;
    read_expect(ADDR_VERSION, w);
    w.raw = '0;
    read_expect(ADDR_CNTRL, w);
    read_expect(ADDR_STATUS, w);
    for (int n = 0; n < NUM_CH; n++) begin
      read_expect(ADDR_CHAN_BASE + 14'(n), w);
    end
    foreach (reg_rows[r]) begin
      w.raw = reg_rows[r].wr;
      bus_write(reg_rows[r].addr, w);
      read_expect(reg_rows[r].addr, reg_rows[r].rd);
    end

    // **************************************************
    // rate generator
    // **************************************************
    foreach (rates[k]) begin
      bus_write(ADDR_CNTRL, cntrl_word(rates[k], 1'b0, 1'b0, 1'b0, 1'b0));
      wait_strobe(rates[k] + 4);
      prev_valid = 1'b1;
      cycles     = 0;
      do begin
        @(negedge dac_clk);
        cycles++;
        check_bit(dac_valid_i0, prev_valid, "dac_valid_i0 one cycle after dac_valid");
        check_bit(dac_valid_q0, prev_valid, "dac_valid_q0 one cycle after dac_valid");
        check_bit(dac_valid_i1, prev_valid, "dac_valid_i1 one cycle after dac_valid");
        check_bit(dac_valid_q1, prev_valid, "dac_valid_q1 one cycle after dac_valid");
        prev_valid = dac_valid;
        if (cycles > rates[k] + 4) report_failure("dac_valid stopped strobing");
      end while (!dac_valid);
      if (cycles != rates[k] + 1) begin
        report_failure($sformatf("mismatch at %0t ns: datarate %0d gave period %0d",
                                 $time, rates[k], cycles));
      end
    end
    // 1r1t drops the second pair
    bus_write(ADDR_CNTRL, cntrl_word(1, 1'b1, 1'b0, 1'b0, 1'b0));
    q0_seen = 1'b0;
    repeat (8) begin
      @(negedge dac_clk);
      check_bit(dac_valid_i1, 1'b0, "dac_valid_i1 in 1r1t mode");
      check_bit(dac_valid_q1, 1'b0, "dac_valid_q1 in 1r1t mode");
      q0_seen = q0_seen | dac_valid_q0;
    end
    check_bit(q0_seen, 1'b1, "dac_valid_q0 strobes in 1r1t mode");

    // **************************************************
    // channel sources
    // **************************************************
    for (int n = 0; n < NUM_CH; n++) begin
      dma_val[n] = 16'($random(seed));
      adc_val[n] = 12'($random(seed));
      cur_src[n] = SRC_DMA;
      cur_en[n]  = 1'b0;
      cur_pat[n] = '0;
      bus_write(ADDR_CHAN_BASE + 14'(n), chan_word(1'b0, SRC_DMA, 12'h000));
    end
    @(posedge dac_clk);
    dac_data_i0 <= dma_val[0];
    dac_data_q0 <= dma_val[1];
    dac_data_i1 <= dma_val[2];
    dac_data_q1 <= dma_val[3];
    adc_data    <= {adc_val[3], adc_val[2], adc_val[1], adc_val[0]};
    foreach (chan_rows[r]) begin
      c = chan_rows[r].ch;
      p = c ^ 1;
      bus_write(ADDR_CNTRL, cntrl_word(2, 1'b0, chan_rows[r].fmt, 1'b0, 1'b0));
      bus_write(ADDR_CHAN_BASE + 14'(c),
                chan_word(chan_rows[r].en, chan_rows[r].src, chan_rows[r].pat));
      cur_src[c] = chan_rows[r].src;
      cur_en[c]  = chan_rows[r].en;
      cur_pat[c] = chan_rows[r].pat;
      partner = model_sample(cur_src[p], cur_en[p], cur_pat[p], chan_rows[r].fmt, p, '0);
      chan_rows[r].exp = model_sample(cur_src[c], cur_en[c], cur_pat[c], chan_rows[r].fmt,
                                      c, partner);
      check_bit(enable_out(c), chan_rows[r].en, "dac_enable follows enable");
      // first strobe lets the partner settle
      wait_strobe(6);
      wait_strobe(6);
      @(negedge dac_clk);
      check_sample(dac_data[SAMPLE_W*c +: SAMPLE_W], chan_rows[r].exp,
                   $sformatf("channel %0d in row %0d", c, r));
    end

    // **************************************************
    // sticky status and sync
    // **************************************************
    @(posedge dac_clk);
    dac_dovf <= 1'b1;
    @(posedge dac_clk);
    dac_dovf <= 1'b0;
    w.raw = 32'h2;
    read_expect(ADDR_STATUS, w);
    @(posedge dac_clk);
    dac_dunf <= 1'b1;
    @(posedge dac_clk);
    dac_dunf <= 1'b0;
    w.raw = 32'h3;
    read_expect(ADDR_STATUS, w);
    read_expect(ADDR_STATUS, w);
    w.raw = 32'h1;
    bus_write(ADDR_STATUS, w);
    w.raw = 32'h2;
    read_expect(ADDR_STATUS, w);
    bus_write(ADDR_STATUS, w);
    w.raw = 32'h0;
    read_expect(ADDR_STATUS, w);

    bus_write(ADDR_CNTRL, cntrl_word(7, 1'b0, 1'b0, 1'b0, 1'b1));
    check_bit(sync_at_ack, 1'b1, "dac_sync_out in the write ack cycle");
    bus_write(ADDR_CNTRL, cntrl_word(7, 1'b0, 1'b0, 1'b1, 1'b0));
    repeat (3) @(posedge dac_clk);
    dac_sync_in <= 1'b1;
    @(posedge dac_clk);
    dac_sync_in <= 1'b0;
    // counter reload edge, then skip the strobe decided before it
    @(posedge dac_clk);
    @(negedge dac_clk);
    cycles = 0;
    do begin
      @(negedge dac_clk);
      cycles++;
      if (cycles > 7 + 4) report_failure("no dac_valid after the external sync");
    end while (!dac_valid);
    if (cycles != 7 + 1) begin
      report_failure($sformatf("mismatch at %0t ns: dac_valid %0d cycles after sync reload",
                               $time, cycles));
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
// testbench clock and reset: 20 ns dac clock, reset held low for five cycles
module tb_clk_gen (
  output logic dac_clk,
  output logic up_rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    dac_clk = 1'b0;
    forever #10 dac_clk = ~dac_clk;
  end

  initial begin
    up_rstn = 1'b0;
    repeat (5) @(posedge dac_clk);
    up_rstn <= 1'b1;
  end

endmodule

// ==== src/axi_tx_core.sv ====
// tx core top: register bank, rate generator and four dac channels
module axi_tx_core
  import ad_tx_pkg::*;
(
  input  logic                     dac_clk,
  input  logic                     up_rstn,
  input  logic                     up_wreq,
  input  logic [ADDR_W-1:0]        up_waddr,
  input  logic [DATA_W-1:0]        up_wdata,
  output logic                     up_wack,
  input  logic                     up_rreq,
  input  logic [ADDR_W-1:0]        up_raddr,
  output logic [DATA_W-1:0]        up_rdata,
  output logic                     up_rack,
  output logic                     dac_valid,
  output logic [NUM_CH*SAMPLE_W-1:0] dac_data,
  input  logic [NUM_CH*SAMPLE_W-1:0] adc_data,
  input  logic                     dac_sync_in,
  output logic                     dac_sync_out,
  output logic                     dac_enable_i0,
  output logic                     dac_enable_q0,
  output logic                     dac_enable_i1,
  output logic                     dac_enable_q1,
  output logic                     dac_valid_i0,
  output logic                     dac_valid_q0,
  output logic                     dac_valid_i1,
  output logic                     dac_valid_q1,
  input  logic [DMA_W-1:0]         dac_data_i0,
  input  logic [DMA_W-1:0]         dac_data_q0,
  input  logic [DMA_W-1:0]         dac_data_i1,
  input  logic [DMA_W-1:0]         dac_data_q1,
  input  logic                     dac_dovf,
  input  logic                     dac_dunf
);

  logic [SAMPLE_W-1:0] data_i0;
  logic [SAMPLE_W-1:0] data_q0;
  logic [SAMPLE_W-1:0] data_i1;
  logic [SAMPLE_W-1:0] data_q1;

  dac_cfg_if dac_cfg ();

  assign dac_data = {data_q1, data_i1, data_q0, data_i0};

  tx_regmap i_tx_regmap (
    .dac_clk (dac_clk), .up_rstn (up_rstn),
    .up_wreq (up_wreq), .up_waddr (up_waddr), .up_wdata (up_wdata), .up_wack (up_wack),
    .up_rreq (up_rreq), .up_raddr (up_raddr), .up_rdata (up_rdata), .up_rack (up_rack),
    .dac_dovf (dac_dovf), .dac_dunf (dac_dunf),
    .dac_sync_out (dac_sync_out), .cfg (dac_cfg.regs));

  tx_rate_gen i_tx_rate_gen (
    .dac_clk (dac_clk), .up_rstn (up_rstn), .dac_sync_in (dac_sync_in),
    .cfg (dac_cfg.core), .dac_valid (dac_valid),
    .dac_valid_i0 (dac_valid_i0), .dac_valid_q0 (dac_valid_q0),
    .dac_valid_i1 (dac_valid_i1), .dac_valid_q1 (dac_valid_q1));

  // **************************************************
  // channels, pairs are 0/1 and 2/3
  // **************************************************

  tx_channel i_tx_channel_0 (
    .dac_clk (dac_clk), .up_rstn (up_rstn), .dac_valid (dac_valid),
    .dma_data (dac_data_i0), .adc_data (adc_data[11:0]), .partner_data (data_q0),
    .enable (dac_cfg.chan_enable[0]), .source (dac_cfg.chan_source[0]),
    .pattern (dac_cfg.chan_pattern[0]), .dds_format (dac_cfg.dds_format),
    .dac_enable (dac_enable_i0), .dac_data (data_i0));

  tx_channel i_tx_channel_1 (
    .dac_clk (dac_clk), .up_rstn (up_rstn), .dac_valid (dac_valid),
    .dma_data (dac_data_q0), .adc_data (adc_data[23:12]), .partner_data (data_i0),
    .enable (dac_cfg.chan_enable[1]), .source (dac_cfg.chan_source[1]),
    .pattern (dac_cfg.chan_pattern[1]), .dds_format (dac_cfg.dds_format),
    .dac_enable (dac_enable_q0), .dac_data (data_q0));

  tx_channel i_tx_channel_2 (
    .dac_clk (dac_clk), .up_rstn (up_rstn), .dac_valid (dac_valid),
    .dma_data (dac_data_i1), .adc_data (adc_data[35:24]), .partner_data (data_q1),
    .enable (dac_cfg.chan_enable[2]), .source (dac_cfg.chan_source[2]),
    .pattern (dac_cfg.chan_pattern[2]), .dds_format (dac_cfg.dds_format),
    .dac_enable (dac_enable_i1), .dac_data (data_i1));

  tx_channel i_tx_channel_3 (
    .dac_clk (dac_clk), .up_rstn (up_rstn), .dac_valid (dac_valid),
    .dma_data (dac_data_q1), .adc_data (adc_data[47:36]), .partner_data (data_i1),
    .enable (dac_cfg.chan_enable[3]), .source (dac_cfg.chan_source[3]),
    .pattern (dac_cfg.chan_pattern[3]), .dds_format (dac_cfg.dds_format),
    .dac_enable (dac_enable_q1), .dac_data (data_q1));

endmodule

// ==== src/tx_channel.sv ====
// tx channel: per-channel sample source select, format conversion and output register
module tx_channel
  import ad_tx_pkg::*;
(
  input  logic                dac_clk,
  input  logic                up_rstn,
  input  logic                dac_valid,
  input  logic [DMA_W-1:0]    dma_data,
  input  logic [SAMPLE_W-1:0] adc_data,
  input  logic [SAMPLE_W-1:0] partner_data,
  input  logic                enable,
  input  logic [1:0]          source,
  input  logic [SAMPLE_W-1:0] pattern,
  input  logic                dds_format,
  output logic                dac_enable,
  output logic [SAMPLE_W-1:0] dac_data
);

  logic [SAMPLE_W-1:0] pattern_fmt;
  logic [SAMPLE_W-1:0] sample_sel;

  // offset binary is two's complement with the msb flipped
  assign pattern_fmt = {pattern[SAMPLE_W-1] ^ dds_format, pattern[SAMPLE_W-2:0]};

  always_comb begin
    case (source)
      SRC_DMA:     sample_sel = dma_data[DMA_W-1 -: SAMPLE_W];
      SRC_PATTERN: sample_sel = pattern_fmt;
      SRC_ADC:     sample_sel = adc_data;
      SRC_PARTNER: sample_sel = partner_data;
      default:     sample_sel = '0;
    endcase
  end

  // **************************************************
  // output register
  // **************************************************

  // partner value is already registered, so no loop through the pair
  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      dac_data <= '0;
    end else if (dac_valid) begin
      dac_data <= enable ? sample_sel : '0;
    end
  end

  assign dac_enable = enable;

  a_disabled_zero: assert property (
    @(posedge dac_clk) disable iff (!up_rstn)
    (dac_valid && !enable) |=> dac_data == '0);

endmodule

// ==== src/tx_rate_gen.sv ====
// tx rate generator: sync select, reloadable rate counter and valid strobes
module tx_rate_gen (
  input  logic    dac_clk,
  input  logic    up_rstn,
  input  logic    dac_sync_in,
  dac_cfg_if.core cfg,
  output logic    dac_valid,
  output logic    dac_valid_i0,
  output logic    dac_valid_q0,
  output logic    dac_valid_i1,
  output logic    dac_valid_q1
);

  logic [15:0] rate_cnt;
  logic        sync_s;
  logic        sync_q;

  // external sync replaces the register strobe
  assign sync_s = cfg.ext_sync ? dac_sync_in : cfg.sync_pulse;

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      sync_q   <= 1'b0;
      rate_cnt <= '0;
    end else begin
      sync_q <= sync_s;
      if (sync_q || rate_cnt == 16'd0) begin
        rate_cnt <= cfg.datarate;
      end else begin
        rate_cnt <= rate_cnt - 16'd1;
      end
    end
  end

  // **************************************************
  // valid strobes, second pair gated in 1r1t
  // **************************************************

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      dac_valid    <= 1'b0;
      dac_valid_i0 <= 1'b0;
      dac_valid_q0 <= 1'b0;
      dac_valid_i1 <= 1'b0;
      dac_valid_q1 <= 1'b0;
    end else begin
      dac_valid    <= rate_cnt == 16'd0;
      dac_valid_i0 <= dac_valid;
      dac_valid_q0 <= dac_valid;
      dac_valid_i1 <= dac_valid & ~cfg.r1_mode;
      dac_valid_q1 <= dac_valid & ~cfg.r1_mode;
    end
  end

  // counter reloaded with a nonzero rate cannot strobe back to back
  a_valid_spacing: assert property (
    @(posedge dac_clk) disable iff (!up_rstn)
    (dac_valid && !sync_q && $past(cfg.datarate) != 16'd0) |=> !dac_valid);

endmodule

// ==== src/tx_regmap.sv ====
// tx register bank: processor strobe bus decode, sync pulse and sticky dma status
module tx_regmap
  import ad_tx_pkg::*;
(
  input  logic              dac_clk,
  input  logic              up_rstn,
  input  logic              up_wreq,
  input  logic [ADDR_W-1:0] up_waddr,
  input  logic [DATA_W-1:0] up_wdata,
  output logic              up_wack,
  input  logic              up_rreq,
  input  logic [ADDR_W-1:0] up_raddr,
  output logic [DATA_W-1:0] up_rdata,
  output logic              up_rack,
  input  logic              dac_dovf,
  input  logic              dac_dunf,
  output logic              dac_sync_out,
  dac_cfg_if.regs           cfg
);

  common_cntrl_t cntrl_q;
  chan_cntrl_t   chan_q [NUM_CH];
  logic [1:0]    status_q;
  logic          sync_q;
  reg_word_u     wword;
  reg_word_u     rword;
  logic          chan_wsel;
  logic          chan_rsel;
  logic [1:0]    status_clr;

  assign wword = up_wdata;

  // channel block is four words from the base
  assign chan_wsel = up_waddr[ADDR_W-1:2] == ADDR_CHAN_BASE[ADDR_W-1:2];
  assign chan_rsel = up_raddr[ADDR_W-1:2] == ADDR_CHAN_BASE[ADDR_W-1:2];

  assign status_clr = (up_wreq && up_waddr == ADDR_STATUS) ? up_wdata[1:0] : 2'b00;

  // **************************************************
  // write side
  // **************************************************

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      sync_q   <= 1'b0;
      cntrl_q  <= '0;
      status_q <= 2'b00;
      for (int n = 0; n < NUM_CH; n++) begin
        chan_q[n] <= '0;
      end
    end else begin
      up_wack <= up_wreq;
      // sync is only a strobe, never held in the register
      sync_q  <= up_wreq && (up_waddr == ADDR_CNTRL) && wword.common.sync;
      if (up_wreq && up_waddr == ADDR_CNTRL) begin
        cntrl_q.datarate   <= wword.common.datarate;
        cntrl_q.r1_mode    <= wword.common.r1_mode;
        cntrl_q.dds_format <= wword.common.dds_format;
        cntrl_q.ext_sync   <= wword.common.ext_sync;
      end
      if (up_wreq && chan_wsel) begin
        chan_q[up_waddr[1:0]].enable  <= wword.chan.enable;
        chan_q[up_waddr[1:0]].source  <= wword.chan.source;
        chan_q[up_waddr[1:0]].pattern <= wword.chan.pattern;
      end
      // set beats clear in the same cycle
      status_q[1] <= (status_q[1] & ~status_clr[1]) | dac_dovf;
      status_q[0] <= (status_q[0] & ~status_clr[0]) | dac_dunf;
    end
  end

  // **************************************************
  // read side
  // **************************************************

  always_comb begin
    rword.raw = '0;
    if (up_raddr == ADDR_VERSION) begin
      rword.raw = CORE_VERSION;
    end else if (up_raddr == ADDR_CNTRL) begin
      rword.common = cntrl_q;
    end else if (up_raddr == ADDR_STATUS) begin
      rword.raw[1:0] = status_q;
    end else if (chan_rsel) begin
      rword.chan = chan_q[up_raddr[1:0]];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rword.raw : '0;
    end
  end

  // config out to the datapath
  assign dac_sync_out   = sync_q;
  assign cfg.sync_pulse = sync_q;
  assign cfg.datarate   = cntrl_q.datarate;
  assign cfg.r1_mode    = cntrl_q.r1_mode;
  assign cfg.dds_format = cntrl_q.dds_format;
  assign cfg.ext_sync   = cntrl_q.ext_sync;

  always_comb begin
    for (int n = 0; n < NUM_CH; n++) begin
      cfg.chan_enable[n]  = chan_q[n].enable;
      cfg.chan_source[n]  = chan_q[n].source;
      cfg.chan_pattern[n] = chan_q[n].pattern;
    end
  end

  a_wack_follows_wreq: assert property (
    @(posedge dac_clk) disable iff (!up_rstn) up_wack |-> $past(up_wreq));

endmodule

// ==== src/dac_cfg_if.sv ====
// dac config interface: decoded register settings from the register bank to the datapath
interface dac_cfg_if
  import ad_tx_pkg::*;
();

  logic [15:0]                      datarate;
  logic                             r1_mode;
  logic                             dds_format;
  logic                             sync_pulse;
  logic                             ext_sync;
  logic [NUM_CH-1:0]                chan_enable;
  logic [NUM_CH-1:0][1:0]           chan_source;
  logic [NUM_CH-1:0][SAMPLE_W-1:0]  chan_pattern;

  // register bank side
  modport regs (
    output datarate, r1_mode, dds_format, sync_pulse, ext_sync,
    output chan_enable, chan_source, chan_pattern
  );

  // datapath side
  modport core (
    input datarate, r1_mode, dds_format, sync_pulse, ext_sync,
    input chan_enable, chan_source, chan_pattern
  );

endinterface

// ==== src/ad_tx_pkg.sv ====
// dac transmit core package: widths, register map and register word layouts
package ad_tx_pkg;

  // **************************************************
  // widths
  // **************************************************

  localparam int SAMPLE_W = 12;
  localparam int DMA_W    = 16;
  localparam int NUM_CH   = 4;
  localparam int ADDR_W   = 14;
  localparam int DATA_W   = 32;

  localparam logic [DATA_W-1:0] CORE_VERSION = 32'h0001_0061;

  // **************************************************
  // register word addresses
  // **************************************************

  localparam logic [ADDR_W-1:0] ADDR_VERSION   = 14'h000;
  localparam logic [ADDR_W-1:0] ADDR_CNTRL     = 14'h010;
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 14'h012;
  // channel n sits at base + n
  localparam logic [ADDR_W-1:0] ADDR_CHAN_BASE = 14'h100;

  // channel source select
  localparam logic [1:0] SRC_DMA     = 2'd0;
  localparam logic [1:0] SRC_PATTERN = 2'd1;
  localparam logic [1:0] SRC_ADC     = 2'd2;
  localparam logic [1:0] SRC_PARTNER = 2'd3;

  // common control register
  typedef struct packed {
    logic [15:0] datarate;
    logic [9:0]  rsvd_15_6;
    logic        ext_sync;
    logic        dds_format;   // offset binary when set
    logic        rsvd_3;
    logic        r1_mode;
    logic        rsvd_1;
    logic        sync;         // self-clearing
  } common_cntrl_t;

  // per-channel control register
  typedef struct packed {
    logic [3:0]          rsvd_31_28;
    logic [SAMPLE_W-1:0] pattern;    // two's complement
    logic [12:0]         rsvd_15_3;
    logic [1:0]          source;
    logic                enable;
  } chan_cntrl_t;

  // one data word, decoded by address
  typedef union packed {
    common_cntrl_t      common;
    chan_cntrl_t        chan;
    logic [DATA_W-1:0]  raw;
  } reg_word_u;

endpackage
